// ==== dcache_pkg.sv ====
package dcache_pkg;

	// cache geometry
	localparam int unsigned num_ways = 4;
	localparam int unsigned num_sets = 16;
	localparam int unsigned set_w = 4;
	localparam int unsigned offset_w = 5;
	localparam int unsigned words_per_line = 8;
	localparam int unsigned tag_w = 32 - set_w - offset_w;

	// every line transfer is 8 beats, so the burst length field is 7
	localparam int unsigned line_burst_len = words_per_line - 1;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0] strb_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [set_w-1:0] set_t;
	typedef logic [$clog2(words_per_line)-1:0] word_sel_t;
	typedef logic [words_per_line*32-1:0] line_t;
	typedef logic [num_ways-1:0] way_vec_t;
	typedef logic [num_ways-2:0] plru_t;
	typedef logic [7:0] burst_len_t;

	typedef enum logic [3:0] {
		idle,
		lookup,
		victim,
		evict_check,
		wb_req,
		wb_data,
		refill_req,
		refill_data,
		refill_write,
		write_hit,
		read_hit,
		respond
	} ctrl_state_t;

endpackage

// ==== dcache_storage.sv ====
module dcache_storage
	import dcache_pkg::*;
(
	input logic clk,
	input logic rst,
	input set_t set,
	input tag_t tag,
	input way_vec_t way_sel,
	input word_sel_t word_sel,
	input word_t wdata,
	input strb_t wstrb,
	input line_t refill_line,
	input logic tag_we,
	input logic data_we,
	input logic refill_sel,
	input logic mark_dirty,
	output way_vec_t hit_way,
	output way_vec_t set_valid,
	output logic sel_dirty,
	output tag_t sel_tag,
	output line_t sel_line,
	output word_t rsp_word
);

	tag_t tag_mem [num_ways][num_sets];
	line_t data_mem [num_ways][num_sets];
	way_vec_t valid_q [num_sets];
	way_vec_t dirty_q [num_sets];

	word_t merged_word;
	line_t merged_line;
	line_t line_wdata;

	// tag compare and one-hot read mux over the selected way
	always_comb begin
		sel_dirty = 1'b0;
		sel_tag = '0;
		sel_line = '0;
		for (int w = 0; w < num_ways; w++) begin
			hit_way[w] = valid_q[set][w] && (tag_mem[w][set] == tag);
			if (way_sel[w]) begin
				sel_dirty = sel_dirty | dirty_q[set][w];
				sel_tag = sel_tag | tag_mem[w][set];
				sel_line = sel_line | data_mem[w][set];
			end
		end
	end

	assign set_valid = valid_q[set];
	assign rsp_word = sel_line[word_sel*32 +: 32];

	// byte strobe merge of the cpu word into the selected line
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			merged_word[b*8 +: 8] = wstrb[b] ? wdata[b*8 +: 8] : rsp_word[b*8 +: 8];
		end
		merged_line = sel_line;
		merged_line[word_sel*32 +: 32] = merged_word;
	end

	assign line_wdata = refill_sel ? refill_line : merged_line;

	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (tag_we && way_sel[w])
				tag_mem[w][set] <= tag;
			if (data_we && way_sel[w])
				data_mem[w][set] <= line_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < num_sets; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else begin
			if (tag_we)
				valid_q[set] <= valid_q[set] | way_sel;
			// a refilled line is clean, a cpu write makes it dirty
			if (data_we && refill_sel)
				dirty_q[set] <= dirty_q[set] & ~way_sel;
			else if (mark_dirty)
				dirty_q[set] <= dirty_q[set] | way_sel;
		end
	end

	a_single_way_write: assert property (@(posedge clk) disable iff (rst)
		(tag_we || data_we || mark_dirty) |-> $onehot0(way_sel));

endmodule

// ==== dcache_plru.sv ====
module dcache_plru
	import dcache_pkg::*;
(
	input logic clk,
	input logic rst,
	input set_t set,
	input way_vec_t set_valid,
	input logic access,
	input way_vec_t way_sel,
	output way_vec_t victim_way
);

	plru_t plru_q [num_sets];
	plru_t cur_bits;
	way_vec_t first_invalid;

	assign cur_bits = plru_q[set];

	// lowest clear bit of set_valid or zero for a full set
	assign first_invalid = ~set_valid & (set_valid + way_vec_t'(1));

	always_comb begin
		if (first_invalid != '0) begin
			victim_way = first_invalid;
		end else if (!cur_bits[0]) begin
			// bit 1 picks way 0 or way 1 in the lower half
			victim_way = cur_bits[1] ? 4'b0010 : 4'b0001;
		end else begin
			victim_way = cur_bits[2] ? 4'b1000 : 4'b0100;
		end
	end

	// the path bits are turned to point away from the accessed way
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < num_sets; s++)
				plru_q[s] <= '0;
		end else if (access) begin
			if (way_sel[0] || way_sel[1]) begin
				plru_q[set][0] <= 1'b1;
				plru_q[set][1] <= way_sel[0];
			end else begin
				plru_q[set][0] <= 1'b0;
				plru_q[set][2] <= way_sel[2];
			end
		end
	end

	// right after an access the accessed way is never the next victim
	a_victim_not_recent: assert property (@(posedge clk) disable iff (rst)
		access |=> (victim_way & $past(way_sel)) == '0);

endmodule

// ==== dcache_line_buffer.sv ====
module dcache_line_buffer
	import dcache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic wb_load,
	input line_t sel_line,
	input logic wr_beat,
	input logic rd_beat,
	input word_t mem_rd_rsp_data,
	output word_t wr_word,
	output logic wr_last,
	output line_t refill_line
);

	line_t wb_shift_q;
	line_t refill_q;
	word_sel_t beat_cnt_q;

	// refill collector
	// each beat enters at the top, so after 8 beats the first one sits in word 0
	always_ff @(posedge clk) begin
		if (rd_beat)
			refill_q <= {mem_rd_rsp_data, refill_q[$bits(line_t)-1:32]};
	end

	assign refill_line = refill_q;

	// write-back shifter, word 0 goes out first
	always_ff @(posedge clk) begin
		if (wb_load)
			wb_shift_q <= sel_line;
		else if (wr_beat)
			wb_shift_q <= {32'b0, wb_shift_q[$bits(line_t)-1:32]};
	end

	assign wr_word = wb_shift_q[31:0];

	// beat counter for the write burst
	always_ff @(posedge clk) begin
		if (rst || wb_load)
			beat_cnt_q <= '0;
		else if (wr_beat)
			beat_cnt_q <= beat_cnt_q + word_sel_t'(1);
	end

	assign wr_last = (beat_cnt_q == word_sel_t'(words_per_line - 1));

endmodule

// ==== dcache_ctrl.sv ====
module dcache_ctrl
	import dcache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic mem_req_valid,
	input logic mem_req,
	input addr_t mem_req_addr,
	input word_t mem_req_wdata,
	input strb_t mem_req_wstrb,
	input logic cache_rsp_ready,
	input logic mem_rd_req_ready,
	input logic mem_rd_rsp_valid,
	input logic mem_rd_rsp_last,
	input logic mem_wr_req_ready,
	input logic mem_wr_data_ready,
	input way_vec_t hit_way,
	input way_vec_t victim_way,
	input logic sel_dirty,
	input tag_t sel_tag,
	input logic wr_last,
	output logic mem_req_ready,
	output logic cache_rsp_valid,
	output logic mem_rd_req_valid,
	output addr_t mem_rd_req_addr,
	output logic mem_rd_rsp_ready,
	output logic mem_wr_req_valid,
	output addr_t mem_wr_req_addr,
	output logic mem_wr_data_valid,
	output set_t set,
	output tag_t tag,
	output word_sel_t word_sel,
	output way_vec_t way_sel,
	output word_t wdata,
	output strb_t wstrb,
	output logic tag_we,
	output logic data_we,
	output logic refill_sel,
	output logic mark_dirty,
	output logic access,
	output logic wb_load
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	logic req_write_q;
	addr_t addr_q;
	word_t wdata_q;
	strb_t wstrb_q;
	way_vec_t way_sel_q;

	// request capture while idle
	always_ff @(posedge clk) begin
		if (state_q == idle && mem_req_valid) begin
			req_write_q <= mem_req;
			addr_q <= mem_req_addr;
			wdata_q <= mem_req_wdata;
			wstrb_q <= mem_req_wstrb;
		end
	end

	// address split
	assign tag = addr_q[31 -: tag_w];
	assign set = addr_q[offset_w +: set_w];
	assign word_sel = addr_q[offset_w-1:2];
	assign wdata = wdata_q;
	assign wstrb = wstrb_q;

	// hit way from lookup or the victim on a miss
	always_ff @(posedge clk) begin
		if (rst)
			way_sel_q <= '0;
		else if (state_q == lookup)
			way_sel_q <= hit_way;
		else if (state_q == victim)
			way_sel_q <= victim_way;
	end

	assign way_sel = way_sel_q;

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= idle;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			idle:
				if (mem_req_valid)
					state_d = lookup;
			lookup:
				if (|hit_way)
					state_d = req_write_q ? write_hit : read_hit;
				else
					state_d = victim;
			victim:
				state_d = evict_check;
			evict_check:
				state_d = sel_dirty ? wb_req : refill_req;
			wb_req:
				if (mem_wr_req_ready)
					state_d = wb_data;
			wb_data:
				if (mem_wr_data_ready && wr_last)
					state_d = refill_req;
			refill_req:
				if (mem_rd_req_ready)
					state_d = refill_data;
			refill_data:
				if (mem_rd_rsp_valid && mem_rd_rsp_last)
					state_d = refill_write;
			refill_write:
				state_d = req_write_q ? write_hit : read_hit;
			write_hit:
				state_d = idle;
			read_hit:
				state_d = respond;
			respond:
				if (cache_rsp_ready)
					state_d = idle;
			default:
				state_d = idle;
		endcase
	end

	// handshakes decoded from the registered state
	assign mem_req_ready = (state_q == idle);
	assign cache_rsp_valid = (state_q == respond);
	assign mem_rd_req_valid = (state_q == refill_req);
	assign mem_rd_rsp_ready = (state_q == refill_data);
	assign mem_wr_req_valid = (state_q == wb_req);
	assign mem_wr_data_valid = (state_q == wb_data);

	// line addresses for refill and write-back
	assign mem_rd_req_addr = {tag, set, {offset_w{1'b0}}};
	assign mem_wr_req_addr = {sel_tag, set, {offset_w{1'b0}}};

	// array strobes
	assign tag_we = (state_q == refill_write);
	assign refill_sel = (state_q == refill_write);
	assign data_we = (state_q == refill_write) || (state_q == write_hit);
	assign mark_dirty = (state_q == write_hit);
	assign access = (state_q == read_hit) || (state_q == write_hit);
	assign wb_load = (state_q == evict_check) && sel_dirty;

	// a waiting response keeps valid and the set, word and way that select its data
	a_rsp_held: assert property (@(posedge clk) disable iff (rst)
		cache_rsp_valid && !cache_rsp_ready |=> cache_rsp_valid && $stable(set)
			&& $stable(word_sel) && $stable(way_sel));

endmodule

// ==== dcache_top.sv ====
module dcache_top
	import dcache_pkg::*;
(
	input logic clk,
	input logic rst,

	// cpu side
	input logic mem_req_valid,
	input logic mem_req,
	input addr_t mem_req_addr,
	input word_t mem_req_wdata,
	input strb_t mem_req_wstrb,
	output logic mem_req_ready,
	output logic cache_rsp_valid,
	output word_t cache_rsp_data,
	input logic cache_rsp_ready,

	// memory read channels
	output logic mem_rd_req_valid,
	output addr_t mem_rd_req_addr,
	output burst_len_t mem_rd_req_len,
	input logic mem_rd_req_ready,
	input logic mem_rd_rsp_valid,
	input word_t mem_rd_rsp_data,
	input logic mem_rd_rsp_last,
	output logic mem_rd_rsp_ready,

	// memory write channels
	output logic mem_wr_req_valid,
	output addr_t mem_wr_req_addr,
	output burst_len_t mem_wr_req_len,
	input logic mem_wr_req_ready,
	output logic mem_wr_data_valid,
	output word_t mem_wr_data,
	output strb_t mem_wr_data_strb,
	output logic mem_wr_data_last,
	input logic mem_wr_data_ready
);

	set_t set;
	tag_t tag;
	word_sel_t word_sel;
	way_vec_t way_sel;
	word_t wdata;
	strb_t wstrb;
	logic tag_we;
	logic data_we;
	logic refill_sel;
	logic mark_dirty;
	logic access;
	logic wb_load;
	way_vec_t hit_way;
	way_vec_t set_valid;
	way_vec_t victim_way;
	logic sel_dirty;
	tag_t sel_tag;
	line_t sel_line;
	line_t refill_line;
	logic wr_last;
	logic wr_beat;
	logic rd_beat;

	// every transfer is a full line write-back or refill
	assign mem_rd_req_len = burst_len_t'(line_burst_len);
	assign mem_wr_req_len = burst_len_t'(line_burst_len);
	assign mem_wr_data_strb = '1;
	assign mem_wr_data_last = wr_last;

	assign wr_beat = mem_wr_data_valid & mem_wr_data_ready;
	assign rd_beat = mem_rd_rsp_valid & mem_rd_rsp_ready;

	dcache_ctrl i_ctrl (
		.clk(clk), .rst(rst),
		.mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_addr(mem_req_addr),
		.mem_req_wdata(mem_req_wdata), .mem_req_wstrb(mem_req_wstrb),
		.cache_rsp_ready(cache_rsp_ready), .mem_rd_req_ready(mem_rd_req_ready),
		.mem_rd_rsp_valid(mem_rd_rsp_valid), .mem_rd_rsp_last(mem_rd_rsp_last),
		.mem_wr_req_ready(mem_wr_req_ready), .mem_wr_data_ready(mem_wr_data_ready),
		.hit_way(hit_way), .victim_way(victim_way), .sel_dirty(sel_dirty),
		.sel_tag(sel_tag), .wr_last(wr_last),
		.mem_req_ready(mem_req_ready), .cache_rsp_valid(cache_rsp_valid),
		.mem_rd_req_valid(mem_rd_req_valid), .mem_rd_req_addr(mem_rd_req_addr),
		.mem_rd_rsp_ready(mem_rd_rsp_ready), .mem_wr_req_valid(mem_wr_req_valid),
		.mem_wr_req_addr(mem_wr_req_addr), .mem_wr_data_valid(mem_wr_data_valid),
		.set(set), .tag(tag), .word_sel(word_sel), .way_sel(way_sel),
		.wdata(wdata), .wstrb(wstrb), .tag_we(tag_we), .data_we(data_we),
		.refill_sel(refill_sel), .mark_dirty(mark_dirty), .access(access),
		.wb_load(wb_load)
	);

	dcache_storage i_storage (
		.clk(clk), .rst(rst), .set(set), .tag(tag), .way_sel(way_sel),
		.word_sel(word_sel), .wdata(wdata), .wstrb(wstrb), .refill_line(refill_line),
		.tag_we(tag_we), .data_we(data_we), .refill_sel(refill_sel),
		.mark_dirty(mark_dirty), .hit_way(hit_way), .set_valid(set_valid),
		.sel_dirty(sel_dirty), .sel_tag(sel_tag), .sel_line(sel_line),
		.rsp_word(cache_rsp_data)
	);

	dcache_plru i_plru (
		.clk(clk), .rst(rst), .set(set), .set_valid(set_valid), .access(access),
		.way_sel(way_sel), .victim_way(victim_way)
	);

	dcache_line_buffer i_line_buffer (
		.clk(clk), .rst(rst), .wb_load(wb_load), .sel_line(sel_line),
		.wr_beat(wr_beat), .rd_beat(rd_beat), .mem_rd_rsp_data(mem_rd_rsp_data),
		.wr_word(mem_wr_data), .wr_last(wr_last), .refill_line(refill_line)
	);

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen (
	output logic clk,
	output logic rst
);

	// period of 20
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset covers the first four rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== tb_dcache.sv ====
module tb_dcache
	import dcache_pkg::*;
();

	localparam int num_requests = 400;
	localparam int wait_limit = 300;
	localparam int table_size = 1024;

	logic clk;
	logic rst;
	logic mem_req_valid;
	logic mem_req;
	addr_t mem_req_addr;
	word_t mem_req_wdata;
	strb_t mem_req_wstrb;
	logic mem_req_ready;
	logic cache_rsp_valid;
	word_t cache_rsp_data;
	logic cache_rsp_ready;
	logic mem_rd_req_valid;
	addr_t mem_rd_req_addr;
	burst_len_t mem_rd_req_len;
	logic mem_rd_req_ready = 1'b0;
	logic mem_rd_rsp_valid = 1'b0;
	word_t mem_rd_rsp_data = '0;
	logic mem_rd_rsp_last = 1'b0;
	logic mem_rd_rsp_ready;
	logic mem_wr_req_valid;
	addr_t mem_wr_req_addr;
	burst_len_t mem_wr_req_len;
	logic mem_wr_req_ready = 1'b0;
	logic mem_wr_data_valid;
	word_t mem_wr_data;
	strb_t mem_wr_data_strb;
	logic mem_wr_data_last;
	logic mem_wr_data_ready = 1'b0;

	// word tables indexed by address bits 11:2, unwritten entries read as the fill pattern
	word_t ref_mem [table_size];
	logic ref_set [table_size];
	word_t back_mem [table_size];
	logic back_set [table_size];

	// reference cache state
	tag_t m_tag [num_sets][num_ways];
	logic m_valid [num_sets][num_ways];
	logic m_dirty [num_sets][num_ways];
	plru_t m_plru [num_sets];

	logic [15:0] cpu_lfsr = 16'd51;
	logic [15:0] mem_lfsr = 16'd51;
	int cpu_errors = 0;
	int mem_errors = 0;
	int exp_rd_count = 0;
	int exp_wb_count = 0;
	int rd_req_count = 0;
	int wr_req_count = 0;
	addr_t exp_rd_addr = '0;
	addr_t exp_wb_addr = '0;
	logic aborted = 1'b0;

	// memory model burst state
	logic rd_active = 1'b0;
	addr_t rd_base = '0;
	int rd_beat = 0;
	logic wb_active = 1'b0;
	addr_t wb_base = '0;
	int wb_beat = 0;

	tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

	dcache_top i_dut (.*);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic word_t cpu_bits(input int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			cpu_lfsr = lfsr_next(cpu_lfsr);
			r = {r[30:0], cpu_lfsr[0]};
		end
		return r;
	endfunction

	function automatic word_t mem_bits(input int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			mem_lfsr = lfsr_next(mem_lfsr);
			r = {r[30:0], mem_lfsr[0]};
		end
		return r;
	endfunction

	function automatic word_t fill_pattern(input addr_t a);
		return {a[15:0], a[31:16]} ^ (a * 32'h9e3779b1) ^ 32'h5a5a0f0f;
	endfunction

	function automatic word_t ref_read(input addr_t a);
		if (ref_set[a[11:2]])
			return ref_mem[a[11:2]];
		return fill_pattern(a);
	endfunction

	function automatic word_t back_read(input addr_t a);
		if (back_set[a[11:2]])
			return back_mem[a[11:2]];
		return fill_pattern(a);
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t nw, input strb_t s);
		word_t r;
		r = old;
		for (int b = 0; b < 4; b++)
			if (s[b])
				r[b*8 +: 8] = nw[b*8 +: 8];
		return r;
	endfunction

	// invalid ways first, then the tree
	function automatic int pick_victim(input int s);
		for (int i = 0; i < num_ways; i++)
			if (!m_valid[s][i])
				return i;
		if (!m_plru[s][0])
			return m_plru[s][1] ? 1 : 0;
		return m_plru[s][2] ? 3 : 2;
	endfunction

	task automatic touch_way(input int s, input int w);
		if (w < 2) begin
			m_plru[s][0] = 1'b1;
			m_plru[s][1] = (w == 0);
		end else begin
			m_plru[s][0] = 1'b0;
			m_plru[s][2] = (w == 2);
		end
	endtask

	task automatic update_model(input logic wr, input addr_t addr, input word_t wd,
			input strb_t ws, output logic hit);
		int s;
		int w;
		tag_t t;
		s = addr[offset_w +: set_w];
		t = addr[31 -: tag_w];
		w = -1;
		for (int i = 0; i < num_ways; i++)
			if (m_valid[s][i] && m_tag[s][i] == t)
				w = i;
		hit = (w >= 0);
		if (!hit) begin
			w = pick_victim(s);
			if (m_valid[s][w] && m_dirty[s][w]) begin
				exp_wb_addr = {m_tag[s][w], set_t'(s), {offset_w{1'b0}}};
				exp_wb_count++;
			end
			exp_rd_addr = {t, set_t'(s), {offset_w{1'b0}}};
			exp_rd_count++;
			m_tag[s][w] = t;
			m_valid[s][w] = 1'b1;
			m_dirty[s][w] = 1'b0;
		end
		touch_way(s, w);
		if (wr) begin
			m_dirty[s][w] = 1'b1;
			ref_mem[addr[11:2]] = merge_bytes(ref_read(addr), wd, ws);
			ref_set[addr[11:2]] = 1'b1;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		cpu_errors++;
		aborted = 1'b1;
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			cpu_errors++;
		end
	endtask

	task automatic run_request(input logic wr, input addr_t addr, input word_t wd,
			input strb_t ws);
		logic hit;
		logic seen;
		logic done;
		word_t exp_data;
		int cycles;
		mem_req_valid <= 1'b1;
		mem_req <= wr;
		mem_req_addr <= addr;
		mem_req_wdata <= wd;
		mem_req_wstrb <= ws;
		cycles = 0;
		done = 1'b0;
		while (!done && !aborted) begin
			@(posedge clk);
			cycles++;
			if (mem_req_ready)
				done = 1'b1;
			else if (cycles > wait_limit)
				report_timeout("request was never accepted");
		end
		if (aborted)
			return;
		mem_req_valid <= 1'b0;
		update_model(wr, addr, wd, ws, hit);
		exp_data = ref_read(addr);
		cycles = 0;
		seen = 1'b0;
		done = 1'b0;
		while (!done && !aborted) begin
			@(posedge clk);
			cycles++;
			if (!wr) begin
				if (cache_rsp_valid) begin
					if (!seen && hit && cycles != 3) begin
						$display("Error: cache_rsp_valid after %0h cycles, expected 3", cycles);
						cpu_errors++;
					end
					seen = 1'b1;
					if (cache_rsp_data !== exp_data) begin
						$display("Error: cache_rsp_data = %h, expected %h (address %h)",
							cache_rsp_data, exp_data, addr);
						cpu_errors++;
					end
					done = cache_rsp_ready;
				end else if (seen) begin
					$display("Response withdrawn before it was taken, address %h", addr);
					cpu_errors++;
					done = 1'b1;
				end
				cache_rsp_ready <= (cpu_bits(1) != 0);
			end else if (mem_req_ready) begin
				if (hit && cycles != 3) begin
					$display("Error: mem_req_ready after %0h cycles, expected 3", cycles);
					cpu_errors++;
				end
				done = 1'b1;
			end
			if (!done && cycles > wait_limit)
				report_timeout(wr ? "write did not complete" : "read response did not arrive");
		end
		if (!aborted && rd_req_count != exp_rd_count) begin
			$display("Error: mem_rd_req count = %h, expected %h", rd_req_count, exp_rd_count);
			cpu_errors++;
		end
		if (!aborted && wr_req_count != exp_wb_count) begin
			$display("Error: mem_wr_req count = %h, expected %h", wr_req_count, exp_wb_count);
			cpu_errors++;
		end
	endtask

	// memory model with random ready delays
	always @(posedge clk) begin
		if (rst) begin
			mem_rd_req_ready <= 1'b0;
			mem_rd_rsp_valid <= 1'b0;
			mem_wr_req_ready <= 1'b0;
			mem_wr_data_ready <= 1'b0;
			rd_active = 1'b0;
			wb_active = 1'b0;
		end else begin
			if (mem_rd_req_valid && mem_rd_req_ready) begin
				if (rd_active || wb_active || rd_req_count >= exp_rd_count
						|| wr_req_count != exp_wb_count) begin
					$display("Unexpected refill request at address %h", mem_rd_req_addr);
					mem_errors++;
				end
				if (mem_rd_req_addr !== exp_rd_addr) begin
					$display("Error: mem_rd_req_addr = %h, expected %h",
						mem_rd_req_addr, exp_rd_addr);
					mem_errors++;
				end
				if (mem_rd_req_len !== 8'd7) begin
					$display("Error: mem_rd_req_len = %h, expected %h", mem_rd_req_len, 8'd7);
					mem_errors++;
				end
				rd_req_count <= rd_req_count + 1;
				rd_active = 1'b1;
				rd_base = mem_rd_req_addr;
				rd_beat = 0;
			end
			if (mem_rd_rsp_valid && mem_rd_rsp_ready)
				rd_beat++;
			if (rd_active && rd_beat < 8) begin
				// an offered beat stays until it is taken
				if (!mem_rd_rsp_valid || mem_rd_rsp_ready) begin
					mem_rd_rsp_valid <= (mem_bits(1) != 0);
					mem_rd_rsp_data <= back_read(rd_base + addr_t'(4 * rd_beat));
					mem_rd_rsp_last <= (rd_beat == 7);
				end
			end else begin
				rd_active = 1'b0;
				mem_rd_rsp_valid <= 1'b0;
			end
			if (mem_wr_req_valid && mem_wr_req_ready) begin
				if (wb_active || wr_req_count >= exp_wb_count) begin
					$display("Write-back of a line that is not a dirty victim, address %h",
						mem_wr_req_addr);
					mem_errors++;
				end
				if (mem_wr_req_addr !== exp_wb_addr) begin
					$display("Error: mem_wr_req_addr = %h, expected %h",
						mem_wr_req_addr, exp_wb_addr);
					mem_errors++;
				end
				if (mem_wr_req_len !== 8'd7) begin
					$display("Error: mem_wr_req_len = %h, expected %h", mem_wr_req_len, 8'd7);
					mem_errors++;
				end
				wr_req_count <= wr_req_count + 1;
				wb_active = 1'b1;
				wb_base = mem_wr_req_addr;
				wb_beat = 0;
			end
			if (mem_wr_data_valid && mem_wr_data_ready) begin
				if (!wb_active) begin
					$display("Write data beat outside a write-back burst");
					mem_errors++;
				end else begin
					if (mem_wr_data !== ref_read(wb_base + addr_t'(4 * wb_beat))) begin
						$display("Error: mem_wr_data = %h, expected %h", mem_wr_data,
							ref_read(wb_base + addr_t'(4 * wb_beat)));
						mem_errors++;
					end
					if (mem_wr_data_strb !== 4'hf) begin
						$display("Error: mem_wr_data_strb = %h, expected %h", mem_wr_data_strb, 4'hf);
						mem_errors++;
					end
					if (mem_wr_data_last !== (wb_beat == 7)) begin
						$display("Error: mem_wr_data_last = %h, expected %h",
							mem_wr_data_last, (wb_beat == 7));
						mem_errors++;
					end
					back_mem[wb_base[11:2] + 10'(wb_beat)] = mem_wr_data;
					back_set[wb_base[11:2] + 10'(wb_beat)] = 1'b1;
					wb_beat++;
					if (wb_beat == 8)
						wb_active = 1'b0;
				end
			end
			mem_rd_req_ready <= (mem_bits(1) != 0);
			mem_wr_req_ready <= (mem_bits(1) != 0);
			mem_wr_data_ready <= (mem_bits(1) != 0);
		end
	end

	initial begin
		addr_t addr;
		addr_t prev_addr;
		logic wr;
		logic [2:0] tag_pick;
		int set_pick;
		int wait_cycles;
		mem_req_valid = 1'b0;
		mem_req = 1'b0;
		mem_req_addr = '0;
		mem_req_wdata = '0;
		mem_req_wstrb = '0;
		cache_rsp_ready = 1'b0;
		for (int i = 0; i < table_size; i++) begin
			ref_set[i] = 1'b0;
			back_set[i] = 1'b0;
		end
		for (int s = 0; s < num_sets; s++) begin
			m_plru[s] = '0;
			for (int w = 0; w < num_ways; w++) begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
			end
		end
		prev_addr = '0;
		wait_cycles = 0;
		@(posedge clk);
		while (rst && !aborted) begin
			@(posedge clk);
			wait_cycles++;
			if (wait_cycles > wait_limit)
				report_timeout("reset was never released");
		end
		expect_bit("mem_req_ready", mem_req_ready, 1'b1);
		expect_bit("cache_rsp_valid", cache_rsp_valid, 1'b0);
		expect_bit("mem_rd_req_valid", mem_rd_req_valid, 1'b0);
		expect_bit("mem_rd_rsp_ready", mem_rd_rsp_ready, 1'b0);
		expect_bit("mem_wr_req_valid", mem_wr_req_valid, 1'b0);
		expect_bit("mem_wr_data_valid", mem_wr_data_valid, 1'b0);
		// three sets and eight tags force conflicts and dirty evictions
		for (int n = 0; n < num_requests && !aborted; n++) begin
			wr = (cpu_bits(1) != 0);
			if (n > 0 && cpu_bits(2) == 0) begin
				addr = prev_addr;
			end else begin
				set_pick = cpu_bits(2) % 3;
				tag_pick = word_sel_t'(cpu_bits(3));
				addr = {tag_t'({20'h5a3c1, tag_pick}),
					set_t'(set_pick == 0 ? 1 : (set_pick == 1 ? 6 : 13)),
					word_sel_t'(cpu_bits(3)), 2'b00};
			end
			run_request(wr, addr, cpu_bits(32), strb_t'(cpu_bits(4)));
			prev_addr = addr;
		end
		$display("Errors: cpu side %0d, memory side %0d", cpu_errors, mem_errors);
		if (cpu_errors == 0 && mem_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
dcache_pkg.sv
dcache_storage.sv
dcache_plru.sv
dcache_line_buffer.sv
dcache_ctrl.sv
dcache_top.sv
tb_clk_gen.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - dcache_pkg.sv
      - dcache_storage.sv
      - dcache_plru.sv
      - dcache_line_buffer.sv
      - dcache_ctrl.sv
      - dcache_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_dcache.sv
